// File: source/emu_cfg_pkg.sv
package emu_cfg_pkg;

   // APB bus widths
   typedef logic [7:0]  apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // Register map, byte offsets
   typedef enum logic [7:0] {
      REG_VIDEO = 8'h00,
      REG_TAPE  = 8'h04,
      REG_ID    = 8'h08
   } reg_addr_e;

   // Bit positions inside REG_VIDEO
   localparam int VID_AR_LSB    = 0;
   localparam int VID_FX_LSB    = 2;
   localparam int VID_SCALE_LSB = 5;
   localparam int VID_CROP_BIT  = 7;

   // Bit positions inside REG_TAPE, rewind reads back as the live pulse
   localparam int TAPE_SRC_BIT  = 0;
   localparam int TAPE_REW_BIT  = 1;

   // Fixed identifier returned by REG_ID ("MSX1")
   localparam apb_data_t EMU_ID = 32'h4D53_5831;

   typedef enum logic {CAS_FILE = 1'b0, CAS_ADC = 1'b1} cas_src_e;
   typedef enum logic {TAPE_EMPTY = 1'b0, TAPE_LOADED = 1'b1} tape_state_e;

   // Download slot of a cassette image
   localparam logic [5:0] CAS_INDEX = 6'd5;

endpackage

// File: source/video_mode_pkg.sv
package video_mode_pkg;

   typedef enum logic [1:0] {AR_ORIGINAL, AR_FULL, AR_CUSTOM1, AR_CUSTOM2} aspect_e;

   typedef enum logic [2:0] {
      FX_NONE, FX_HQ2X_320, FX_HQ2X_160, FX_CRT25, FX_CRT50, FX_CRT75
   } sl_fx_e;

   typedef logic [9:0]  crop_t;
   typedef logic [11:0] hdmi_dim_t;
   typedef logic [11:0] ar_t;

   // Known HDMI heights and the visible line count cropped for each
   localparam hdmi_dim_t H_480  = 12'd480;
   localparam hdmi_dim_t H_600  = 12'd600;
   localparam hdmi_dim_t H_720  = 12'd720;
   localparam hdmi_dim_t H_768  = 12'd768;
   localparam hdmi_dim_t H_800  = 12'd800;
   localparam hdmi_dim_t H_1080 = 12'd1080;
   localparam hdmi_dim_t H_1200 = 12'd1200;
   localparam hdmi_dim_t H_1440 = 12'd1440;
   localparam hdmi_dim_t H_1536 = 12'd1536;
   localparam crop_t CROP_480  = 10'd240;
   localparam crop_t CROP_600  = 10'd200;
   localparam crop_t CROP_720  = 10'd240;
   localparam crop_t CROP_768  = 10'd256;
   localparam crop_t CROP_800  = 10'd200;
   localparam crop_t CROP_1080 = 10'd216;
   localparam crop_t CROP_1200 = 10'd240;
   localparam crop_t CROP_1440 = 10'd240;
   localparam crop_t CROP_1536 = 10'd256;

   // 4:3 modes such as 1920x1440 only crop above this width
   localparam hdmi_dim_t WIDE_LIMIT_W = 12'd1440;

   localparam ar_t AR_X_NORMAL = 12'd400;
   localparam ar_t AR_X_WIDE   = 12'd340;
   localparam ar_t AR_Y_NORMAL = 12'd300;

endpackage

// File: source/cfg_if.sv
`timescale 1ns/100ps

interface cfg_if import emu_cfg_pkg::*, video_mode_pkg::*; ();

   // Video fields
   aspect_e   aspect;
   sl_fx_e    sl_fx;
   logic [1:0] scale;
   logic      vcrop_en;

   // Tape fields
   cas_src_e  cas_src;
   logic      rewind_req;

   // Register block owns every field
   modport regs (output aspect, sl_fx, scale, vcrop_en, cas_src, rewind_req);

   modport video (input aspect, sl_fx, scale, vcrop_en);

   modport tape (input cas_src, rewind_req);

endinterface

// File: source/emu_regs.sv
`timescale 1ns/100ps

module emu_regs import emu_cfg_pkg::*, video_mode_pkg::*; (
   input  logic      clk21m,
   input  logic      rst,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  apb_addr_t paddr,
   input  apb_data_t pwdata,
   output apb_data_t prdata,
   output logic      pready,
   output logic      pslverr,
   cfg_if.regs       cfg
);

   logic access;
   logic addr_ok;
   logic wr_en;

   // Access phase of an APB transfer
   assign access  = psel & penable;
   assign addr_ok = paddr inside {REG_VIDEO, REG_TAPE, REG_ID};
   assign wr_en   = access & pwrite;

   // No wait states
   assign pready = 1'b1;

   // Unmapped offset, or a write to the read-only ID
   assign pslverr = access & (~addr_ok | (pwrite & (paddr == REG_ID)));

   always_ff @(posedge clk21m) begin
      if (rst) begin
         cfg.aspect     <= AR_ORIGINAL;
         cfg.sl_fx      <= FX_NONE;
         cfg.scale      <= 2'd0;
         cfg.vcrop_en   <= 1'b0;
         cfg.cas_src    <= CAS_FILE;
         cfg.rewind_req <= 1'b0;
      end else begin
         // Rewind request is a single-cycle strobe
         cfg.rewind_req <= 1'b0;
         if (wr_en) begin
            case (paddr)
               REG_VIDEO: begin
                  cfg.aspect   <= aspect_e'(pwdata[VID_AR_LSB +: 2]);
                  cfg.sl_fx    <= sl_fx_e'(pwdata[VID_FX_LSB +: 3]);
                  cfg.scale    <= pwdata[VID_SCALE_LSB +: 2];
                  cfg.vcrop_en <= pwdata[VID_CROP_BIT];
               end
               REG_TAPE: begin
                  cfg.cas_src    <= cas_src_e'(pwdata[TAPE_SRC_BIT]);
                  cfg.rewind_req <= pwdata[TAPE_REW_BIT];
               end
               // ID and unmapped offsets ignore writes
               default: ;
            endcase
         end
      end
   end

   // Read mux, valid during the access phase
   always_comb begin
      prdata = '0;
      case (paddr)
         REG_VIDEO: begin
            prdata[VID_AR_LSB +: 2]    = cfg.aspect;
            prdata[VID_FX_LSB +: 3]    = cfg.sl_fx;
            prdata[VID_SCALE_LSB +: 2] = cfg.scale;
            prdata[VID_CROP_BIT]       = cfg.vcrop_en;
         end
         REG_TAPE: begin
            prdata[TAPE_SRC_BIT] = cfg.cas_src;
            prdata[TAPE_REW_BIT] = cfg.rewind_req;
         end
         REG_ID:  prdata = EMU_ID;
         default: prdata = '0;
      endcase
   end

endmodule

// File: source/video_crop.sv
`timescale 1ns/100ps

module video_crop import video_mode_pkg::*; (
   input  logic       clk21m,
   input  logic       rst,
   input  hdmi_dim_t  hdmi_width,
   input  hdmi_dim_t  hdmi_height,
   input  logic       forced_scandoubler,
   cfg_if.video       cfg,
   output crop_t      crop_size,
   output ar_t        ar_x,
   output ar_t        ar_y,
   output logic [1:0] vga_sl,
   output logic [1:0] scale
);

   logic        scandoubler;
   logic        wide_fmt;
   logic [12:0] height_x15;
   crop_t       crop_nxt;
   logic        wide_nxt;
   logic        wide_q;

   // Any scanline effect runs through the scandoubler
   assign scandoubler = (cfg.sl_fx != FX_NONE) | forced_scandoubler;

   // Width at least 1.5 x height, one extra bit against overflow
   assign height_x15 = {1'b0, hdmi_height} + {2'b00, hdmi_height[11:1]};
   assign wide_fmt   = {1'b0, hdmi_width} >= height_x15;

   always_comb begin
      crop_nxt = '0;
      wide_nxt = 1'b0;
      if (!scandoubler) begin
         if (wide_fmt) begin
            case (hdmi_height)
               H_480:  crop_nxt = CROP_480;
               H_600: begin
                  crop_nxt = CROP_600;
                  wide_nxt = cfg.vcrop_en;
               end
               H_720:  crop_nxt = CROP_720;
               H_768:  crop_nxt = CROP_768;
               H_800: begin
                  crop_nxt = CROP_800;
                  wide_nxt = cfg.vcrop_en;
               end
               H_1080: crop_nxt = CROP_1080;
               H_1200: crop_nxt = CROP_1200;
               H_1440: crop_nxt = CROP_1440;
               H_1536: crop_nxt = CROP_1536;
               default: ;
            endcase
         end else if (hdmi_width >= WIDE_LIMIT_W) begin
            // 4:3 modes at large widths
            if (hdmi_height == H_1440) crop_nxt = CROP_1440;
            if (hdmi_height == H_1536) crop_nxt = CROP_1536;
         end
      end
   end

   always_ff @(posedge clk21m) begin
      if (rst) begin
         crop_size <= '0;
         wide_q    <= 1'b0;
      end else begin
         crop_size <= cfg.vcrop_en ? crop_nxt : '0;
         wide_q    <= wide_nxt;
      end
   end

   // Original aspect is 4:3, narrowed when the crop widens the picture
   assign ar_x = (cfg.aspect == AR_ORIGINAL) ? (wide_q ? AR_X_WIDE : AR_X_NORMAL)
                                             : ar_t'(cfg.aspect) - ar_t'(1);
   assign ar_y = (cfg.aspect == AR_ORIGINAL) ? AR_Y_NORMAL : '0;

   // CRT effects map onto scanline levels 1..3
   assign vga_sl = (cfg.sl_fx > FX_HQ2X_160) ? 2'(cfg.sl_fx - 3'd2) : 2'd0;
   assign scale  = cfg.scale;

endmodule

// File: source/sd_activity.sv
`timescale 1ns/100ps

module sd_activity #(
   parameter int SD_HOLD = 1000000
) (
   input  logic        clk21m,
   input  logic        rst,
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        core_sck,
   input  logic        core_mosi,
   input  logic        vsd_miso,
   input  logic        sd_miso,
   output logic        core_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        vsd_active,
   output logic        sd_active
);

   logic        vsd_sel;
   logic        mosi_q;
   logic        miso_q;
   logic [31:0] timer;
   logic        act;

   // Virtual card takes the bus while an image is mounted
   assign sd_cs     = vsd_sel;
   assign sd_sck    = core_sck & ~vsd_sel;
   assign sd_mosi   = core_mosi & ~vsd_sel;
   assign core_miso = vsd_sel ? vsd_miso : sd_miso;

   // Previous line values for toggle detection
   always_ff @(posedge clk21m) begin
      mosi_q <= core_mosi;
      miso_q <= core_miso;
   end

   always_ff @(posedge clk21m) begin
      if (rst) begin
         vsd_sel <= 1'b0;
         timer   <= 32'(SD_HOLD);
         act     <= 1'b0;
      end else begin
         if (img_mounted)
            vsd_sel <= |img_size;
         // Saturating counter, flag stays up until it reaches the hold
         act <= 1'b0;
         if (timer < 32'(SD_HOLD)) begin
            timer <= timer + 32'd1;
            act   <= 1'b1;
         end
         // Any bus traffic restarts the hold
         if ((mosi_q ^ core_mosi) || (miso_q ^ core_miso))
            timer <= '0;
      end
   end

   // Activity goes to the LED of the card in use
   assign vsd_active = vsd_sel & act;
   assign sd_active  = ~vsd_sel & act;

endmodule

// File: source/tape_control.sv
`timescale 1ns/100ps

module tape_control import emu_cfg_pkg::*; (
   input  logic       clk21m,
   input  logic       rst,
   input  logic       ioctl_download,
   input  logic [5:0] ioctl_index,
   input  logic       motor,
   input  logic       cas_file_bit,
   input  logic       adc_bit,
   input  logic       adc_valid,
   cfg_if.tape        cfg,
   output logic       play,
   output logic       rewind,
   output logic       cas_audio
);

   tape_state_e state;
   logic        cas_dl;
   logic        cas_dl_q;

   // Download into the cassette slot
   assign cas_dl = ioctl_download & (ioctl_index == CAS_INDEX);

   always_ff @(posedge clk21m) begin
      if (rst) begin
         state    <= TAPE_EMPTY;
         cas_dl_q <= 1'b0;
      end else begin
         cas_dl_q <= cas_dl;
         // End of the image download loads the tape
         if (cas_dl_q & ~cas_dl)
            state <= TAPE_LOADED;
      end
   end

   // Motor line is active low
   assign play   = (state == TAPE_LOADED) & ~motor;
   assign rewind = rst | cas_dl | cfg.rewind_req;

   // ADC bit only counts while the sampler reports a valid level
   assign cas_audio = (cfg.cas_src == CAS_FILE) ? cas_file_bit : (adc_bit & adc_valid);

endmodule

// File: source/emu_top.sv
`timescale 1ns/100ps

module emu_top import emu_cfg_pkg::*, video_mode_pkg::*; #(
   parameter int SD_HOLD = 1000000
) (
   input  logic        clk21m,
   input  logic        rst,
   // APB
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  apb_addr_t   paddr,
   input  apb_data_t   pwdata,
   output apb_data_t   prdata,
   output logic        pready,
   output logic        pslverr,
   // HDMI output sizing
   input  hdmi_dim_t   hdmi_width,
   input  hdmi_dim_t   hdmi_height,
   input  logic        forced_scandoubler,
   output crop_t       crop_size,
   output ar_t         ar_x,
   output ar_t         ar_y,
   output logic [1:0]  vga_sl,
   output logic [1:0]  scale,
   // SD card
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        core_sck,
   input  logic        core_mosi,
   input  logic        vsd_miso,
   input  logic        sd_miso,
   output logic        core_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        led_user,
   output logic [1:0]  led_disk,
   // Cassette
   input  logic        ioctl_download,
   input  logic [5:0]  ioctl_index,
   input  logic        motor,
   input  logic        cas_file_bit,
   input  logic        adc_bit,
   input  logic        adc_valid,
   output logic        play,
   output logic        rewind,
   output logic        cas_audio
);

   logic vsd_active;
   logic sd_active;

   cfg_if cfg_bus ();

   emu_regs u_regs (
      .clk21m  (clk21m),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .cfg     (cfg_bus.regs)
   );

   video_crop u_video (
      .clk21m             (clk21m),
      .rst                (rst),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .cfg                (cfg_bus.video),
      .crop_size          (crop_size),
      .ar_x               (ar_x),
      .ar_y               (ar_y),
      .vga_sl             (vga_sl),
      .scale              (scale)
   );

   sd_activity #(.SD_HOLD(SD_HOLD)) u_sd (
      .clk21m      (clk21m),
      .rst         (rst),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .core_sck    (core_sck),
      .core_mosi   (core_mosi),
      .vsd_miso    (vsd_miso),
      .sd_miso     (sd_miso),
      .core_miso   (core_miso),
      .sd_cs       (sd_cs),
      .sd_sck      (sd_sck),
      .sd_mosi     (sd_mosi),
      .vsd_active  (vsd_active),
      .sd_active   (sd_active)
   );

   tape_control u_tape (
      .clk21m         (clk21m),
      .rst            (rst),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .motor          (motor),
      .cas_file_bit   (cas_file_bit),
      .adc_bit        (adc_bit),
      .adc_valid      (adc_valid),
      .cfg            (cfg_bus.tape),
      .play           (play),
      .rewind         (rewind),
      .cas_audio      (cas_audio)
   );

   // Disk LED bit 1 set so bit 0 alone controls it
   assign led_user = vsd_active;
   assign led_disk = {1'b1, sd_active};

endmodule

// File: dv/emu_checker.sv
`timescale 1ns/100ps

module emu_checker import emu_cfg_pkg::*; #(
   parameter int SD_HOLD = 64
) (
   input logic        clk21m,
   input logic        rst,
   input logic        psel,
   input logic        penable,
   input logic        pwrite,
   input logic [7:0]  paddr,
   input logic [31:0] pwdata,
   input logic [31:0] prdata,
   input logic        pready,
   input logic        pslverr,
   input logic [11:0] hdmi_width,
   input logic [11:0] hdmi_height,
   input logic        forced_scandoubler,
   input logic [9:0]  crop_size,
   input logic [11:0] ar_x,
   input logic [11:0] ar_y,
   input logic [1:0]  vga_sl,
   input logic [1:0]  scale,
   input logic        img_mounted,
   input logic [31:0] img_size,
   input logic        core_sck,
   input logic        core_mosi,
   input logic        vsd_miso,
   input logic        sd_miso,
   input logic        core_miso,
   input logic        sd_cs,
   input logic        sd_sck,
   input logic        sd_mosi,
   input logic        led_user,
   input logic [1:0]  led_disk,
   input logic        ioctl_download,
   input logic [5:0]  ioctl_index,
   input logic        motor,
   input logic        cas_file_bit,
   input logic        adc_bit,
   input logic        adc_valid,
   input logic        play,
   input logic        rewind,
   input logic        cas_audio
);

   int err_count    = 0;
   int test_err     = 0;
   int tests_run    = 0;
   int tests_failed = 0;
   bit valid        = 0;

   // Shadow of the register fields
   logic [1:0] m_ar;
   logic [2:0] m_fx;
   logic [1:0] m_scale;
   logic       m_crop_en;
   logic       m_src;
   logic       m_rew;
   // Registered video outputs
   logic [9:0] m_crop_size;
   logic       m_wide;
   // SD routing and activity
   logic       m_vsd;
   logic       m_act;
   int         quiet;
   logic       prev_mosi;
   logic       prev_miso;
   // Tape
   logic       m_loaded;
   logic       m_dl_prev;

   // Returns {wide, crop} for the given mode
   function automatic logic [10:0] ref_crop(input logic [11:0] w, input logic [11:0] h,
                                            input logic [2:0] fx, input logic forced,
                                            input logic crop_en);
      int c;
      logic wd;
      c  = 0;
      wd = 1'b0;
      if (fx == 3'd0 && !forced) begin
         if (2 * int'(w) >= 3 * int'(h)) begin
            case (int'(h))
               480, 720, 1200, 1440: c = 240;
               600, 800: begin
                  c  = 200;
                  wd = crop_en;
               end
               768, 1536: c = 256;
               1080: c = 216;
               default: c = 0;
            endcase
         end else if (int'(w) >= 1440) begin
            if (int'(h) == 1440) c = 240;
            if (int'(h) == 1536) c = 256;
         end
      end
      return {wd, 10'(c)};
   endfunction

   function automatic logic [11:0] ref_ar_x(input logic [1:0] ar, input logic wide);
      if (ar == 2'd0)
         return wide ? 12'd340 : 12'd400;
      return {10'd0, ar} - 12'd1;
   endfunction

   function automatic logic [1:0] ref_vga_sl(input logic [2:0] fx);
      logic [2:0] d;
      d = fx - 3'd2;
      return (fx > 3'd2) ? d[1:0] : 2'd0;
   endfunction

   function automatic logic [31:0] ref_read(input logic [7:0] addr);
      case (addr)
         8'h00: return {24'd0, m_crop_en, m_scale, m_fx, m_ar};
         8'h04: return {30'd0, m_rew, m_src};
         8'h08: return 32'h4D53_5831;
         default: return 32'd0;
      endcase
   endfunction

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (got !== exp) begin
         $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
         err_count++;
         test_err++;
      end
   endtask

   task automatic test_done(input string name);
      tests_run++;
      if (test_err != 0)
         tests_failed++;
      $display("Test %s: %s, %0d mismatches", name, (test_err == 0) ? "ok" : "bad", test_err);
      test_err = 0;
   endtask

   task automatic report_counts();
      $display("Tests run %0d, tests bad %0d, mismatches %0d",
               tests_run, tests_failed, err_count);
   endtask

   // Compare on the rising edge, then step the model
   always @(posedge clk21m) begin
      logic [10:0] cw;
      logic        access;
      logic        exp_miso;
      logic        dl;
      logic        tog;
      logic        bad_addr;
      access   = psel & penable;
      exp_miso = m_vsd ? vsd_miso : sd_miso;
      dl       = ioctl_download && (ioctl_index == 6'd5);
      bad_addr = !(paddr == 8'h00 || paddr == 8'h04 || paddr == 8'h08);
      if (valid) begin
         check("pready", 32'd1, {31'd0, pready});
         if (access) begin
            check("pslverr", {31'd0, bad_addr | (pwrite & (paddr == 8'h08))}, {31'd0, pslverr});
            if (!pwrite)
               check("prdata", ref_read(paddr), prdata);
         end
         check("crop_size", {22'd0, m_crop_size}, {22'd0, crop_size});
         check("ar_x", {20'd0, ref_ar_x(m_ar, m_wide)}, {20'd0, ar_x});
         check("ar_y", (m_ar == 2'd0) ? 32'd300 : 32'd0, {20'd0, ar_y});
         check("vga_sl", {30'd0, ref_vga_sl(m_fx)}, {30'd0, vga_sl});
         check("scale", {30'd0, m_scale}, {30'd0, scale});
         check("sd_cs", {31'd0, m_vsd}, {31'd0, sd_cs});
         check("sd_sck", {31'd0, core_sck & !m_vsd}, {31'd0, sd_sck});
         check("sd_mosi", {31'd0, core_mosi & !m_vsd}, {31'd0, sd_mosi});
         check("core_miso", {31'd0, exp_miso}, {31'd0, core_miso});
         check("led_user", {31'd0, m_vsd & m_act}, {31'd0, led_user});
         check("led_disk", {30'd0, 1'b1, !m_vsd & m_act}, {30'd0, led_disk});
         check("play", {31'd0, m_loaded & !motor}, {31'd0, play});
         check("rewind", {31'd0, rst | dl | m_rew}, {31'd0, rewind});
         check("cas_audio", {31'd0, m_src ? (adc_bit & adc_valid) : cas_file_bit},
               {31'd0, cas_audio});
      end
      tog       = (core_mosi !== prev_mosi) || (exp_miso !== prev_miso);
      prev_mosi = core_mosi;
      prev_miso = exp_miso;
      if (rst) begin
         {m_ar, m_fx, m_scale, m_crop_en, m_src, m_rew} = '0;
         m_crop_size = '0;
         m_wide      = 1'b0;
         m_vsd       = 1'b0;
         m_act       = 1'b0;
         quiet       = SD_HOLD;
         m_loaded    = 1'b0;
         m_dl_prev   = 1'b0;
         valid       = 1'b1;
      end else begin
         // Crop follows the fields as they stood before this edge
         cw          = ref_crop(hdmi_width, hdmi_height, m_fx, forced_scandoubler, m_crop_en);
         m_crop_size = m_crop_en ? cw[9:0] : 10'd0;
         m_wide      = cw[10];
         if (img_mounted)
            m_vsd = |img_size;
         // LED lit for SD_HOLD edges after the edge that saw the toggle
         m_act = (quiet < SD_HOLD);
         if (tog)
            quiet = 0;
         else if (quiet < SD_HOLD)
            quiet++;
         if (m_dl_prev && !dl)
            m_loaded = 1'b1;
         m_dl_prev = dl;
         m_rew     = 1'b0;
         if (access && pwrite) begin
            if (paddr == 8'h00)
               {m_crop_en, m_scale, m_fx, m_ar} = pwdata[7:0];
            if (paddr == 8'h04)
               {m_rew, m_src} = pwdata[1:0];
         end
      end
   end

endmodule

// File: dv/emu_sva.sv
`timescale 1ns/100ps

module emu_sva (
   input logic clk21m,
   input logic rst,
   input logic penable,
   input logic pready,
   input logic rewind_req,
   input logic sd_cs,
   input logic sd_sck
);

   // No wait states on the APB side
   a_pready: assert property (@(posedge clk21m) disable iff (rst) penable |-> pready)
      else $error("pready low during an APB access phase");

   // Rewind strobe is a single cycle
   a_rewind: assert property (@(posedge clk21m) disable iff (rst) rewind_req |=> !rewind_req)
      else $error("rewind_req held for two cycles");

   // Physical card clock is gated while the virtual card is in use
   a_sck: assert property (@(posedge clk21m) disable iff (rst) sd_cs |-> !sd_sck)
      else $error("sd_sck toggles while sd_cs is high");

endmodule

bind emu_top emu_sva sva_chk (
   .clk21m     (clk21m),
   .rst        (rst),
   .penable    (penable),
   .pready     (pready),
   .rewind_req (cfg_bus.rewind_req),
   .sd_cs      (sd_cs),
   .sd_sck     (sd_sck)
);

// File: dv/emu_tb.sv
`timescale 1ns/100ps

module emu_tb import emu_cfg_pkg::*; ();

   localparam int SD_HOLD    = 64;
   // Rough cycle budget of all tests together
   localparam int RUN_CYCLES = 1400 + 8 * SD_HOLD;
   localparam int WATCHDOG_NS = 2 * RUN_CYCLES * 40;

   logic        clk21m = 1'b0;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [7:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [11:0] hdmi_width;
   logic [11:0] hdmi_height;
   logic        forced_scandoubler;
   logic [9:0]  crop_size;
   logic [11:0] ar_x;
   logic [11:0] ar_y;
   logic [1:0]  vga_sl;
   logic [1:0]  scale;
   logic        img_mounted;
   logic [31:0] img_size;
   logic        core_sck;
   logic        core_mosi;
   logic        vsd_miso;
   logic        sd_miso;
   logic        core_miso;
   logic        sd_cs;
   logic        sd_sck;
   logic        sd_mosi;
   logic        led_user;
   logic [1:0]  led_disk;
   logic        ioctl_download;
   logic [5:0]  ioctl_index;
   logic        motor;
   logic        cas_file_bit;
   logic        adc_bit;
   logic        adc_valid;
   logic        play;
   logic        rewind;
   logic        cas_audio;

   logic [15:0] lfsr = 16'd41;
   int          hs_err = 0;

   // 40 ns period
   always #20 clk21m = ~clk21m;

   emu_top #(.SD_HOLD(SD_HOLD)) uut (.*);

   emu_checker #(.SD_HOLD(SD_HOLD)) chk (.*);

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        lsb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[30:0], lfsr[0]};
         lsb  = lfsr[0];
         lfsr = lfsr >> 1;
         if (lsb)
            lfsr = lfsr ^ 16'hB400;
      end
      return r;
   endfunction

   task automatic tick(input int n);
      repeat (n) @(negedge clk21m);
   endtask

   task automatic reset_dut();
      @(negedge clk21m);
      rst = 1'b1;
      tick(3);
      rst = 1'b0;
   endtask

   task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data);
      int n;
      n = 0;
      @(negedge clk21m);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk21m);
      penable = 1'b1;
      @(posedge clk21m);
      while (!pready && n < 16) begin
         @(posedge clk21m);
         n++;
      end
      if (!pready) begin
         $display("APB access to %h never saw pready", addr);
         hs_err++;
      end
      @(negedge clk21m);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic mount(input logic [31:0] size);
      @(negedge clk21m);
      img_mounted = 1'b1;
      img_size    = size;
      @(negedge clk21m);
      img_mounted = 1'b0;
   endtask

   // Watchdog
   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int heights[9];
      int h;
      int w;
      logic [2:0] fx;
      heights = '{480, 600, 720, 768, 800, 1080, 1200, 1440, 1536};
      rst = 1'b1;
      {psel, penable, pwrite, paddr, pwdata} = '0;
      hdmi_width = 12'd1920;
      hdmi_height = 12'd1080;
      forced_scandoubler = 1'b0;
      {img_mounted, img_size, core_sck, core_mosi, vsd_miso, sd_miso} = '0;
      {ioctl_download, ioctl_index, motor, cas_file_bit, adc_bit, adc_valid} = '0;
      tick(3);
      rst = 1'b0;

      // APB register map
      apb_access(1'b1, REG_VIDEO, rand_bits(32));
      apb_access(1'b0, REG_VIDEO, 32'd0);
      apb_access(1'b1, REG_TAPE, 32'h1);
      apb_access(1'b0, REG_TAPE, 32'd0);
      apb_access(1'b0, REG_ID, 32'd0);
      apb_access(1'b1, REG_ID, 32'hFFFF_FFFF);
      apb_access(1'b0, 8'h0C, 32'd0);
      apb_access(1'b1, 8'h10, 32'hFF);
      apb_access(1'b0, REG_VIDEO, 32'd0);
      apb_access(1'b0, REG_TAPE, 32'd0);
      chk.test_done("apb_registers");

      // Crop and aspect over table and random sizes
      for (int i = 0; i < 40; i++) begin
         h = int'(rand_bits(4)) % 10;
         h = (h == 9) ? int'(rand_bits(11)) : heights[h];
         case (rand_bits(2))
            0: w = 2 * h;
            1: w = (4 * h) / 3;
            2: w = 1920;
            default: w = int'(rand_bits(12));
         endcase
         fx = (rand_bits(2) == 0) ? 3'(rand_bits(3) % 6) : 3'd0;
         apb_access(1'b1, REG_VIDEO, {24'd0, 3'(rand_bits(3)), fx, 2'(rand_bits(2))});
         @(negedge clk21m);
         hdmi_width = 12'(w);
         hdmi_height = 12'(h);
         forced_scandoubler = (rand_bits(3) == 0);
         tick(3);
      end
      // Each table height at 2:1 with crop on and original aspect
      apb_access(1'b1, REG_VIDEO, 32'h80);
      for (int i = 0; i < 9; i++) begin
         @(negedge clk21m);
         hdmi_width = 12'(2 * heights[i]);
         hdmi_height = 12'(heights[i]);
         forced_scandoubler = 1'b0;
         tick(3);
      end
      chk.test_done("crop_aspect");

      // Virtual and physical card routing
      mount(rand_bits(16) | 32'd1);
      for (int i = 0; i < 24; i++) begin
         {core_sck, core_mosi, vsd_miso, sd_miso} = 4'(rand_bits(4));
         tick(1);
      end
      mount(32'd0);
      for (int i = 0; i < 24; i++) begin
         {core_sck, core_mosi, vsd_miso, sd_miso} = 4'(rand_bits(4));
         tick(1);
      end
      chk.test_done("sd_routing");

      // Activity LED hold on each card
      reset_dut();
      tick(4);
      for (int v = 0; v < 2; v++) begin
         mount(32'(v));
         tick(SD_HOLD + 4);
         core_mosi = ~core_mosi;
         tick(SD_HOLD + 4);
         for (int k = 0; k < 4; k++) begin
            core_mosi = ~core_mosi;
            tick(1 + int'(rand_bits(3)));
         end
         tick(SD_HOLD + 4);
      end
      chk.test_done("activity_led");

      // Cassette load, rewind and audio source
      apb_access(1'b1, REG_TAPE, 32'h0);
      ioctl_index = 6'd3;
      ioctl_download = 1'b1;
      tick(5);
      ioctl_download = 1'b0;
      tick(3);
      ioctl_index = 6'd5;
      ioctl_download = 1'b1;
      tick(5);
      ioctl_download = 1'b0;
      for (int i = 0; i < 12; i++) begin
         {motor, cas_file_bit, adc_bit, adc_valid} = 4'(rand_bits(4));
         tick(1);
      end
      apb_access(1'b1, REG_TAPE, 32'h3);
      for (int i = 0; i < 12; i++) begin
         {motor, cas_file_bit, adc_bit, adc_valid} = 4'(rand_bits(4));
         tick(1);
      end
      apb_access(1'b1, REG_TAPE, 32'h2);
      reset_dut();
      tick(4);
      chk.test_done("tape");

      chk.report_counts();
      if (chk.err_count == 0 && hs_err == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

// File: emu_top.f
source/emu_cfg_pkg.sv
source/video_mode_pkg.sv
source/cfg_if.sv
source/emu_regs.sv
source/video_crop.sv
source/sd_activity.sv
source/tape_control.sv
source/emu_top.sv
dv/emu_checker.sv
dv/emu_sva.sv
dv/emu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the emu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module emu_tb -f emu_top.f --Mdir obj_dir -o emu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/emu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qF "*** TEST PASSED ***"; then
   exit 0
fi
exit 1
